/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := game_link_tb
FILELIST := sim.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))
DATA     := tests/game_link_input.txt

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: $(BIN) $(DATA)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "=== FAIL ===" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* hdl/byte_fifo.sv */
// Synchronous byte queue between the frame encoder and the serial transmitter
`timescale 1ns/1ps

module byte_fifo
    import game_link_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       wr_en,
    input  logic [7:0] wr_data,
    output logic       full,
    input  logic       rd_en,
    output logic [7:0] rd_data,
    output logic       empty
);

    logic [7:0]         mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               do_wr;
    logic               do_rd;

    // Flags straight from the occupancy register
    assign full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign empty = (count == '0);

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // Head of queue, valid whenever empty is low
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hdl/game_frame_encoder.sv */
// Frame encoder that snapshots changed game state and queues an 11-byte frame
`timescale 1ns/1ps

module game_frame_encoder
    import game_link_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  game_state_t state,
    input  logic        full,
    output logic [7:0]  wr_data,
    output logic        wr_en
);

    typedef enum logic {
        IDLE,
        SENDING
    } enc_state_t;

    enc_state_t  ctrl;
    logic [3:0]  step;
    game_state_t snap;
    logic        changed;
    logic        last_step;

    // Any field differing from the last frame sent
    assign changed   = (state != snap);
    assign last_step = (step == 4'(FRAME_LEN - 1));

    // One write per cycle while sending, held off by back-pressure
    assign wr_en = (ctrl == SENDING) && !full;

    //////////////////////////////////////////////////////////////////////
    // Frame byte selection, always from the held snapshot
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (step)
            4'd0:    wr_data = FRAME_HEADER;
            4'd1:    wr_data = snap.char_x[7:0];
            4'd2:    wr_data = {4'b0, snap.char_x[11:8]};
            4'd3:    wr_data = snap.char_y[7:0];
            4'd4:    wr_data = {4'b0, snap.char_y[11:8]};
            4'd5:    wr_data = {4'b0, snap.char_hp};
            4'd6:    wr_data = {4'b0, snap.char_aggro};
            4'd7:    wr_data = {7'b0, snap.flip_h};
            4'd8:    wr_data = {6'b0, snap.char_class};
            4'd9:    wr_data = {1'b0, snap.boss_hp};
            4'd10:   wr_data = {7'b0, snap.game_start};
            default: wr_data = 8'h00;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl <= IDLE;
            step <= '0;
            snap <= '0;
        end else begin
            case (ctrl)
                IDLE: begin
                    // Latch now, header goes out on the next edge
                    if (changed) begin
                        snap <= state;
                        step <= '0;
                        ctrl <= SENDING;
                    end
                end
                SENDING: begin
                    if (wr_en) begin
                        if (last_step) begin
                            step <= '0;
                            ctrl <= IDLE;
                        end else begin
                            step <= step + 4'd1;
                        end
                    end
                end
                default: ctrl <= IDLE;
            endcase
        end
    end

endmodule

/* hdl/game_link_pkg.sv */
// Game status link shared types, frame format and serial/queue constants
package game_link_pkg;

    //////////////////////////////////////////////////////////////////////
    // Frame format
    //////////////////////////////////////////////////////////////////////

    // Leading byte of every frame, ASCII "D"
    localparam logic [7:0] FRAME_HEADER = 8'h44;

    // Header plus ten payload bytes
    localparam int FRAME_LEN = 11;

    //////////////////////////////////////////////////////////////////////
    // Byte queue
    //////////////////////////////////////////////////////////////////////

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = 4;

    //////////////////////////////////////////////////////////////////////
    // Serial line
    //////////////////////////////////////////////////////////////////////

    // Small divider so that simulation runs stay short
    localparam int CLKS_PER_BIT = 16;
    localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);

    //////////////////////////////////////////////////////////////////////
    // Game state
    //////////////////////////////////////////////////////////////////////

    // Player and boss state as seen by the host
    typedef struct packed {
        logic [11:0] char_x;
        logic [11:0] char_y;
        logic [3:0]  char_hp;
        logic [3:0]  char_aggro;
        logic        flip_h;
        logic [1:0]  char_class;
        logic [6:0]  boss_hp;
        logic        game_start;
    } game_state_t;

endpackage

/* hdl/game_link_top.sv */
// Game status link top level joining encoder, byte queue and serial transmitter
`timescale 1ns/1ps

module game_link_top
    import game_link_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  game_state_t state,
    output logic        tx
);

    // Encoder to queue
    logic [7:0] wr_data;
    logic       wr_en;
    logic       full;

    // Queue to transmitter
    logic [7:0] rd_data;
    logic       rd_en;
    logic       empty;

    game_frame_encoder u_enc (
        .clk     (clk),
        .rst     (rst),
        .state   (state),
        .full    (full),
        .wr_data (wr_data),
        .wr_en   (wr_en)
    );

    byte_fifo u_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .full    (full),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .empty   (empty)
    );

    uart_tx u_tx (
        .clk     (clk),
        .rst     (rst),
        .empty   (empty),
        .rd_data (rd_data),
        .rd_en   (rd_en),
        .tx      (tx)
    );

endmodule

/* hdl/uart_tx.sv */
// 8N1 serial transmitter that drains bytes from the queue back to back
`timescale 1ns/1ps

module uart_tx
    import game_link_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       empty,
    input  logic [7:0] rd_data,
    output logic       rd_en,
    output logic       tx
);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } phase_t;

    phase_t               phase;
    logic [BIT_CNT_W-1:0] timer;
    logic [2:0]           bit_idx;
    logic [7:0]           shift;
    logic                 bit_end;

    assign bit_end = (timer == BIT_CNT_W'(CLKS_PER_BIT - 1));

    // Pop from idle, or right at the end of a stop bit for back to back bytes
    assign rd_en = !empty && ((phase == IDLE) || ((phase == STOP) && bit_end));

    // Data bits leave LSB first
    always_ff @(posedge clk) begin
        if (rd_en) begin
            shift <= rd_data;
        end else if (bit_end && ((phase == START) || (phase == DATA))) begin
            shift <= {1'b0, shift[7:1]};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Bit sequencing
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase   <= IDLE;
            timer   <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;
        end else if (rd_en) begin
            phase <= START;
            timer <= '0;
            tx    <= 1'b0;
        end else begin
            timer <= bit_end ? '0 : timer + 1'b1;
            case (phase)
                IDLE: begin
                    timer <= '0;
                    tx    <= 1'b1;
                end
                START: begin
                    if (bit_end) begin
                        phase   <= DATA;
                        bit_idx <= '0;
                        tx      <= shift[0];
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            phase <= STOP;
                            tx    <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                            tx      <= shift[0];
                        end
                    end
                end
                STOP: begin
                    // Queue was empty at the end of the stop bit
                    if (bit_end) begin
                        phase <= IDLE;
                    end
                end
                default: phase <= IDLE;
            endcase
        end
    end

endmodule

/* sim.f */
hdl/game_link_pkg.sv
hdl/game_frame_encoder.sv
hdl/byte_fifo.sv
hdl/uart_tx.sv
hdl/game_link_top.sv
tests/tb_clock_gen.sv
tests/game_link_props.sv
tests/game_link_tb.sv

/* tests/game_link_input.txt */
# char_x char_y char_hp char_aggro flip_h char_class boss_hp game_start (hex)
# then hold time in cycles and frame expected flag (decimal)
000 000 0 0 0 0 00 0 300 0
abc 000 0 0 0 0 00 0 1900 1
abc 5e7 0 0 0 0 00 0 1900 1
abc 5e7 9 0 0 0 00 0 1900 1
abc 5e7 9 c 0 0 00 0 1900 1
abc 5e7 9 c 1 0 00 0 1900 1
abc 5e7 9 c 1 2 00 0 1900 1
abc 5e7 9 c 1 2 5a 0 1900 1
abc 5e7 9 c 1 2 5a 1 1900 1
abc 5e7 9 c 1 2 5a 1 2500 0
fff fff 9 c 1 2 5a 1 1900 1
123 fff 9 c 1 2 5a 1 3 1
456 fff 9 c 1 2 5a 1 5 0
789 fff 3 c 1 2 5a 1 100 1
789 fff 3 c 1 2 11 1 100 0
789 fff 3 c 1 1 22 1 6000 1
789 fff 3 c 1 1 22 0 1900 1

/* tests/game_link_props.sv */
// Bound checks on the byte queue handshake and the serial line bit width
`timescale 1ns/1ps

module game_link_props
    import game_link_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic wr_en,
    input logic full,
    input logic rd_en,
    input logic empty,
    input logic tx
);

    logic [FIFO_AW:0] occ;
    logic             prev_tx;
    logic [7:0]       run_len;

    // Shadow occupancy from the raw strobes and length of the current run on the line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            occ     <= '0;
            prev_tx <= 1'b1;
            run_len <= 8'(CLKS_PER_BIT);
        end else begin
            occ     <= occ + (FIFO_AW + 1)'(wr_en) - (FIFO_AW + 1)'(rd_en);
            prev_tx <= tx;
            if (tx != prev_tx) begin
                run_len <= 8'd1;
            end else if (run_len != 8'hff) begin
                run_len <= run_len + 8'd1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Queue handshake
    //////////////////////////////////////////////////////////////////////

    no_write_when_full: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> (occ != (FIFO_AW + 1)'(FIFO_DEPTH)))
        else $error("Encoder wrote while the queue was full");

    no_read_when_empty: assert property (@(posedge clk) disable iff (rst)
        rd_en |-> (occ != '0))
        else $error("Transmitter popped while the queue was empty");

    full_matches_depth: assert property (@(posedge clk) disable iff (rst)
        full == (occ == (FIFO_AW + 1)'(FIFO_DEPTH)))
        else $error("Full flag disagrees with the queue occupancy");

    empty_matches_zero: assert property (@(posedge clk) disable iff (rst)
        empty == (occ == '0))
        else $error("Empty flag disagrees with the queue occupancy");

    //////////////////////////////////////////////////////////////////////
    // Serial line
    //////////////////////////////////////////////////////////////////////

    // Every level on the line lasts at least one whole bit time
    min_bit_width: assert property (@(posedge clk) disable iff (rst)
        (tx != prev_tx) |-> (run_len >= 8'(CLKS_PER_BIT)))
        else $error("Serial line level shorter than one bit time");

endmodule

bind game_link_top game_link_props u_props (
    .clk   (clk),
    .rst   (rst),
    .wr_en (wr_en),
    .full  (full),
    .rd_en (rd_en),
    .empty (empty),
    .tx    (tx)
);

/* tests/game_link_tb.sv */
// Testbench for the game status link, replaying state records and decoding the serial line
`timescale 1ns/1ps

module game_link_tb
    import game_link_pkg::*;
();

    localparam int BYTE_CLKS  = 10 * CLKS_PER_BIT;
    localparam int QUIET_CLKS = FRAME_LEN * BYTE_CLKS;

    logic        clk;
    logic        rst;
    game_state_t state;
    logic        tx;

    // Records from the data file
    game_state_t rec_state [$];
    int          rec_hold [$];
    bit          rec_frame [$];

    logic [7:0]  exp_q [$];
    logic [7:0]  rx_q [$];
    int          exp_total;
    int          rx_total;
    int          wd_cycles;
    bit          wd_armed;

    tb_clock_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    game_link_top u_dut (
        .clk   (clk),
        .rst   (rst),
        .state (state),
        .tx    (tx)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "Run stopped on the first error");
    endtask

    // Header, then each field zero-extended into its own byte, coordinates split low/high
    function automatic void queue_frame(input game_state_t s);
        exp_q.push_back(FRAME_HEADER);
        exp_q.push_back(s.char_x[7:0]);
        exp_q.push_back(8'(s.char_x[11:8]));
        exp_q.push_back(s.char_y[7:0]);
        exp_q.push_back(8'(s.char_y[11:8]));
        exp_q.push_back(8'(s.char_hp));
        exp_q.push_back(8'(s.char_aggro));
        exp_q.push_back(8'(s.flip_h));
        exp_q.push_back(8'(s.char_class));
        exp_q.push_back(8'(s.boss_hp));
        exp_q.push_back(8'(s.game_start));
        exp_total += FRAME_LEN;
    endfunction

    task automatic load_records();
        int          fd;
        int          n;
        string       line;
        int          f [10];
        game_state_t s;
        fd = $fopen("tests/game_link_input.txt", "r");
        assert (fd != 0) else abort_run("Could not open the stimulus file");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0) begin
                break;
            end
            if ((line.len() < 2) || (line.getc(0) == "#")) begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %d %d",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
            assert (n == 10) else abort_run({"Malformed stimulus record: ", line});
            s.char_x     = 12'(f[0]);
            s.char_y     = 12'(f[1]);
            s.char_hp    = 4'(f[2]);
            s.char_aggro = 4'(f[3]);
            s.flip_h     = 1'(f[4]);
            s.char_class = 2'(f[5]);
            s.boss_hp    = 7'(f[6]);
            s.game_start = 1'(f[7]);
            rec_state.push_back(s);
            rec_hold.push_back(f[8]);
            rec_frame.push_back(f[9] != 0);
        end
        $fclose(fd);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin : drive_records
        int i;
        state     = '0;
        exp_total = 0;
        rx_total  = 0;
        load_records();
        wd_cycles = QUIET_CLKS + 2000;
        foreach (rec_hold[k]) begin
            wd_cycles += rec_hold[k] + (rec_frame[k] ? FRAME_LEN * BYTE_CLKS : 0);
        end
        wd_armed = 1'b1;
        wait (rst == 1'b0);
        @(negedge clk);
        assert (tx === 1'b1) else abort_run($sformatf("[ERROR] tx exp 0x1 got 0x%0h", tx));
        for (i = 0; i < rec_state.size(); i++) begin
            state = rec_state[i];
            if (rec_frame[i]) begin
                queue_frame(rec_state[i]);
            end
            repeat (rec_hold[i]) @(negedge clk);
        end
        while (rx_total < exp_total) begin
            @(negedge clk);
        end
        // A stray frame would show up within this window
        repeat (QUIET_CLKS) @(negedge clk);
        if (tx === 1'b1) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            abort_run($sformatf("[ERROR] tx exp 0x1 got 0x%0h", tx));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Serial decode and byte compare
    //////////////////////////////////////////////////////////////////////

    // Samples near the middle of each bit, on the falling clock edge
    initial begin : decode_line
        logic [7:0] data;
        int         b;
        wait (rst == 1'b0);
        forever begin
            @(negedge tx);
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            assert (tx == 1'b0)
                else abort_run($sformatf("[ERROR] start_bit exp 0x0 got 0x%0h", tx));
            for (b = 0; b < 8; b++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                data[b] = tx;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            assert (tx == 1'b1)
                else abort_run($sformatf("[ERROR] stop_bit exp 0x1 got 0x%0h", tx));
            rx_q.push_back(data);
        end
    end

    initial begin : compare_bytes
        logic [7:0] got;
        logic [7:0] want;
        forever begin
            @(negedge clk);
            while (rx_q.size() > 0) begin
                got = rx_q.pop_front();
                assert (exp_q.size() > 0)
                    else abort_run($sformatf("Byte 0x%02h arrived with no frame expected", got));
                want = exp_q.pop_front();
                assert (got == want)
                    else abort_run($sformatf("[ERROR] rx_byte exp 0x%02h got 0x%02h", want, got));
                rx_total++;
            end
        end
    end

    initial begin : watchdog
        wait (wd_armed);
        repeat (wd_cycles) @(posedge clk);
        abort_run($sformatf("Watchdog expired after %0d cycles, run did not finish", wd_cycles));
    end

endmodule

/* tests/tb_clock_gen.sv */
// Testbench clock and reset source, 10 ns period with reset held for two cycles
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Released on a falling edge, after two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
    end

endmodule
